// ==== compile.f ====
logic/flash_if_pkg.sv
logic/card_cfg_pkg.sv
logic/flash_stream_rx.sv
logic/crc32_byte_check.sv
logic/card_load_ctrl.sv
logic/card_cfg_loader.sv
verif/card_cfg_loader_checker.sv
verif/card_cfg_loader_tb.sv

// ==== logic/card_cfg_loader.sv ====
`timescale 1ns/1ps

module card_cfg_loader #(
	parameter int unsigned                           LOAD_LENGTH    = 868,
	parameter logic [flash_if_pkg::FLASH_ADDR_W-1:0] LOAD_BASE_ADDR = 25'h4E400,
	parameter int                                    FIFO_DEPTH     = 4
) (
	input  logic                        sys_clk,
	input  logic                        glbl_rst_n,
	input  logic                        load_start,
	output flash_if_pkg::flash_rd_req_t flash_rd_req,
	input  flash_if_pkg::flash_beat_t   flash_beat_in,
	output logic                        flash_credit,
	output card_cfg_pkg::card_wr_t      card_wr,
	output card_cfg_pkg::load_result_t  load_result,
	output logic                        load_busy
);

	import flash_if_pkg::*;

	flash_beat_t fifo_beat;
	logic        is_payload;
	logic        crc_result_valid;
	logic        crc_ok;

	//////////////////////////////////////////////////
	// Flash input FIFO with credit return
	//////////////////////////////////////////////////

	flash_stream_rx #(
		.FIFO_DEPTH (FIFO_DEPTH)
	) u_stream_rx (
		.sys_clk    (sys_clk),
		.glbl_rst_n (glbl_rst_n),
		.beat_in    (flash_beat_in),
		.beat_out   (fifo_beat),
		.credit     (flash_credit)
	);

	// CRC over payload, compare against trailer
	crc32_byte_check u_crc_check (
		.sys_clk          (sys_clk),
		.glbl_rst_n       (glbl_rst_n),
		.beat             (fifo_beat),
		.is_payload       (is_payload),
		.crc_result_valid (crc_result_valid),
		.crc_ok           (crc_ok)
	);

	card_load_ctrl #(
		.LOAD_LENGTH    (LOAD_LENGTH),
		.LOAD_BASE_ADDR (LOAD_BASE_ADDR)
	) u_load_ctrl (
		.sys_clk          (sys_clk),
		.glbl_rst_n       (glbl_rst_n),
		.load_start       (load_start),
		.beat             (fifo_beat),
		.crc_result_valid (crc_result_valid),
		.crc_ok           (crc_ok),
		.is_payload       (is_payload),
		.rd_req           (flash_rd_req),
		.card_wr          (card_wr),
		.load_result      (load_result),
		.load_busy        (load_busy)
	);

endmodule

// ==== logic/card_cfg_pkg.sv ====
//////////////////////////////////////////////////
// Card side types and CRC constants
//////////////////////////////////////////////////

package card_cfg_pkg;

	// Card RAM is 1K bytes
	localparam int CARD_ADDR_W = 10;

	// Reflected CRC-32, init and final xor are both all ones
	localparam logic [31:0] CRC32_POLY = 32'hEDB8_8320;
	localparam logic [31:0] CRC32_INIT = 32'hFFFF_FFFF;

	typedef struct packed {
		logic                   valid;
		logic [CARD_ADDR_W-1:0] addr;
		logic [7:0]             data;
	} card_wr_t;

	typedef enum logic {
		LOAD_OK,
		LOAD_CRC_ERROR
	} load_status_e;

	typedef struct packed {
		logic         valid;
		load_status_e status;
	} load_result_t;

	typedef enum logic [1:0] {
		IDLE,
		REQUEST,
		STREAM,
		CHECK
	} loader_state_e;

endpackage

// ==== logic/card_load_ctrl.sv ====
`timescale 1ns/1ps

module card_load_ctrl #(
	parameter int unsigned                           LOAD_LENGTH    = 868,
	parameter logic [flash_if_pkg::FLASH_ADDR_W-1:0] LOAD_BASE_ADDR = 25'h4E400
) (
	input  logic                        sys_clk,
	input  logic                        glbl_rst_n,
	input  logic                        load_start,
	input  flash_if_pkg::flash_beat_t   beat,
	input  logic                        crc_result_valid,
	input  logic                        crc_ok,
	output logic                        is_payload,
	output flash_if_pkg::flash_rd_req_t rd_req,
	output card_cfg_pkg::card_wr_t      card_wr,
	output card_cfg_pkg::load_result_t  load_result,
	output logic                        load_busy
);

	import flash_if_pkg::*;
	import card_cfg_pkg::*;

	// Last four image bytes are the stored CRC
	localparam logic [FLASH_LEN_W-1:0] PAYLOAD_LEN = FLASH_LEN_W'(LOAD_LENGTH - 4);

	loader_state_e          state;
	logic [FLASH_LEN_W-1:0] byte_cnt;

	logic                   wr_valid;
	logic [CARD_ADDR_W-1:0] wr_addr;
	logic [7:0]             wr_data;

	logic                   res_valid;
	load_status_e           res_status;

	assign is_payload = (state == STREAM) && (byte_cnt < PAYLOAD_LEN);
	assign load_busy  = (state != IDLE);

	// Request is held for the single REQUEST cycle
	always_comb
	begin
		rd_req.valid  = (state == REQUEST);
		rd_req.addr   = LOAD_BASE_ADDR;
		rd_req.length = FLASH_LEN_W'(LOAD_LENGTH);
	end

	assign card_wr     = '{valid: wr_valid, addr: wr_addr, data: wr_data};
	assign load_result = '{valid: res_valid, status: res_status};

	//////////////////////////////////////////////////
	// Load FSM
	//////////////////////////////////////////////////

	always_ff @(posedge sys_clk)
	begin
		if (!glbl_rst_n)
		begin
			state     <= IDLE;
			byte_cnt  <= '0;
			wr_valid  <= 1'b0;
			res_valid <= 1'b0;
		end
		else
		begin
			wr_valid  <= 1'b0;
			res_valid <= 1'b0;
			case (state)
				IDLE:
				begin
					if (load_start)
					begin
						byte_cnt <= '0;
						state    <= REQUEST;
					end
				end
				REQUEST:
					state <= STREAM;
				STREAM:
				begin
					if (beat.valid)
					begin
						byte_cnt <= byte_cnt + 1'b1;
						wr_valid <= is_payload;
						if (beat.last)
							state <= CHECK;
					end
				end
				CHECK:
				begin
					// wait for the verdict from the CRC block
					if (crc_result_valid)
					begin
						res_valid <= 1'b1;
						state     <= IDLE;
					end
				end
				default:
					state <= IDLE;
			endcase
		end
	end

	// Write address follows the payload byte count
	always_ff @(posedge sys_clk)
	begin
		wr_addr    <= byte_cnt[CARD_ADDR_W-1:0];
		wr_data    <= beat.data;
		res_status <= crc_ok ? LOAD_OK : LOAD_CRC_ERROR;
	end

endmodule

// ==== logic/crc32_byte_check.sv ====
`timescale 1ns/1ps

module crc32_byte_check (
	input  logic                      sys_clk,
	input  logic                      glbl_rst_n,
	input  flash_if_pkg::flash_beat_t beat,
	input  logic                      is_payload,
	output logic                      crc_result_valid,
	output logic                      crc_ok
);

	import card_cfg_pkg::*;

	logic [31:0] crc_reg;
	logic [31:0] stored_crc;
	logic [31:0] stored_full;

	// One byte through the reflected CRC, LSB first
	function automatic logic [31:0] crc32_step(
		input logic [31:0] crc_in,
		input logic [7:0]  data
	);
		logic [31:0] c;
		c = crc_in ^ {24'h0, data};
		for (int i = 0; i < 8; i++)
		begin
			if (c[0])
				c = (c >> 1) ^ CRC32_POLY;
			else
				c = c >> 1;
		end
		return c;
	endfunction

	// Stored CRC including the byte on the bus right now
	assign stored_full = {beat.data, stored_crc[31:8]};

	//////////////////////////////////////////////////
	// Running CRC and verdict
	//////////////////////////////////////////////////

	always_ff @(posedge sys_clk)
	begin
		if (!glbl_rst_n)
		begin
			crc_reg          <= CRC32_INIT;
			crc_result_valid <= 1'b0;
			crc_ok           <= 1'b0;
		end
		else
		begin
			crc_result_valid <= 1'b0;
			if (beat.valid && beat.last)
			begin
				crc_result_valid <= 1'b1;
				crc_ok           <= ((crc_reg ^ CRC32_INIT) == stored_full);
				// Ready for the next image
				crc_reg          <= CRC32_INIT;
			end
			else if (beat.valid && is_payload)
				crc_reg <= crc32_step(crc_reg, beat.data);
		end
	end

	// Trailer bytes shift in low byte first
	always_ff @(posedge sys_clk)
	begin
		if (beat.valid && !is_payload)
			stored_crc <= stored_full;
	end

endmodule

// ==== logic/flash_if_pkg.sv ====
//////////////////////////////////////////////////
// Flash side types
//////////////////////////////////////////////////

package flash_if_pkg;

	// Flash byte address and read length widths
	localparam int FLASH_ADDR_W = 25;
	localparam int FLASH_LEN_W  = 24;

	// One read request toward the flash controller
	typedef struct packed {
		logic                    valid;
		logic [FLASH_ADDR_W-1:0] addr;
		logic [FLASH_LEN_W-1:0]  length;
	} flash_rd_req_t;

	// One byte beat returned by flash
	// last marks the final byte of the requested image
	typedef struct packed {
		logic       valid;
		logic [7:0] data;
		logic       last;
	} flash_beat_t;

endpackage

// ==== logic/flash_stream_rx.sv ====
`timescale 1ns/1ps

module flash_stream_rx #(
	parameter int FIFO_DEPTH = 4
) (
	input  logic                      sys_clk,
	input  logic                      glbl_rst_n,
	input  flash_if_pkg::flash_beat_t beat_in,
	output flash_if_pkg::flash_beat_t beat_out,
	output logic                      credit
);

	import flash_if_pkg::*;

	localparam int PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
	localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

	// Beat storage, payload only
	flash_beat_t      mem [FIFO_DEPTH];
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [CNT_W-1:0] occupancy;

	logic push;
	logic pop;

	assign push = beat_in.valid;
	// Downstream never stalls, so the head always leaves
	assign pop = (occupancy != '0);

	// One credit back per drained byte
	assign credit = pop;

	always_comb
	begin
		beat_out       = mem[rd_ptr];
		beat_out.valid = pop;
		beat_out.last  = pop & mem[rd_ptr].last;
	end

	always_ff @(posedge sys_clk)
	begin
		if (push)
			mem[wr_ptr] <= beat_in;
	end

	//////////////////////////////////////////////////
	// Pointers and occupancy
	//////////////////////////////////////////////////

	always_ff @(posedge sys_clk)
	begin
		if (!glbl_rst_n)
		begin
			wr_ptr    <= '0;
			rd_ptr    <= '0;
			occupancy <= '0;
		end
		else
		begin
			if (push)
				wr_ptr <= (wr_ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
			if (pop)
				rd_ptr <= (rd_ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
			case ({push, pop})
				2'b10:   occupancy <= occupancy + 1'b1;
				2'b01:   occupancy <= occupancy - 1'b1;
				default: occupancy <= occupancy;
			endcase
		end
	end

endmodule

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the loader testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f compile.f \
	--top-module card_cfg_loader_tb -o card_cfg_loader_sim

./obj_dir/card_cfg_loader_sim > sim.log 2>&1 || { cat sim.log; exit 1; }
cat sim.log

if grep -q "Verification failed" sim.log; then
	exit 1
fi

// ==== verif/card_cfg_loader_checker.sv ====
`timescale 1ns/1ps

module card_cfg_loader_checker #(
	parameter int FIFO_DEPTH = 4,
	parameter int CNT_W      = 3
) (
	input logic                        sys_clk,
	input logic                        glbl_rst_n,
	input logic [CNT_W-1:0]            occupancy,
	input logic                        rd_req_valid,
	input logic                        res_valid,
	input card_cfg_pkg::loader_state_e state
);

	import card_cfg_pkg::*;

	// FIFO never holds more beats than there are credits
	occupancy_bound: assert property (@(posedge sys_clk) disable iff (!glbl_rst_n)
		occupancy <= CNT_W'(FIFO_DEPTH))
		else $error("FIFO occupancy %0d above depth %0d", occupancy, FIFO_DEPTH);

	// Single cycle read request
	single_request: assert property (@(posedge sys_clk) disable iff (!glbl_rst_n)
		rd_req_valid |=> !rd_req_valid)
		else $error("Flash read request held for two cycles");

	// Result only comes out of CHECK
	result_from_check: assert property (@(posedge sys_clk) disable iff (!glbl_rst_n)
		res_valid |-> $past(state) == CHECK)
		else $error("Load result raised outside CHECK");

endmodule

bind flash_stream_rx card_cfg_loader_checker #(
	.FIFO_DEPTH (FIFO_DEPTH),
	.CNT_W      (CNT_W)
) u_fifo_checker (
	.sys_clk      (sys_clk),
	.glbl_rst_n   (glbl_rst_n),
	.occupancy    (occupancy),
	.rd_req_valid (1'b0),
	.res_valid    (1'b0),
	.state        (card_cfg_pkg::IDLE)
);

bind card_load_ctrl card_cfg_loader_checker #(
	.CNT_W (1)
) u_ctrl_checker (
	.sys_clk      (sys_clk),
	.glbl_rst_n   (glbl_rst_n),
	.occupancy    (1'b0),
	.rd_req_valid (rd_req.valid),
	.res_valid    (res_valid),
	.state        (state)
);

// ==== verif/card_cfg_loader_tb.sv ====
`timescale 1ns/1ps

module card_cfg_loader_tb;

	import flash_if_pkg::*;
	import card_cfg_pkg::*;

	localparam int                    LOAD_LENGTH  = 40;
	localparam int                    PAYLOAD_LEN  = LOAD_LENGTH - 4;
	localparam int                    FIFO_DEPTH   = 4;
	localparam logic [FLASH_ADDR_W-1:0] BASE_ADDR  = 25'h4E400;
	localparam int                    RESET_CYCLES = 10;
	localparam int                    MAX_GAP      = 7;
	localparam int                    NUM_TESTS    = 9;
	// Worst case per load plus slack for request and verdict
	localparam int TIMEOUT_CYCLES = NUM_TESTS * (LOAD_LENGTH * (MAX_GAP + 2) + 100);

	logic         sys_clk;
	logic         glbl_rst_n    = 1'b0;
	logic         load_start    = 1'b0;
	flash_beat_t  flash_beat_in = '0;
	flash_rd_req_t flash_rd_req;
	logic         flash_credit;
	card_wr_t     card_wr;
	load_result_t load_result;
	logic         load_busy;

	int           seed = 1;
	int           errors = 0;
	int           checks = 0;
	logic [7:0]   image [LOAD_LENGTH];
	card_wr_t     exp_wr [$];
	load_status_e exp_status;
	int           credits;
	int           gap_max;
	int           gap_cnt;
	int           send_idx;
	int           extra_credits;
	int           req_count;
	int           result_count;
	bit           sending;

	card_cfg_loader #(
		.LOAD_LENGTH    (LOAD_LENGTH),
		.LOAD_BASE_ADDR (BASE_ADDR),
		.FIFO_DEPTH     (FIFO_DEPTH)
	) UUT (
		.sys_clk       (sys_clk),
		.glbl_rst_n    (glbl_rst_n),
		.load_start    (load_start),
		.flash_rd_req  (flash_rd_req),
		.flash_beat_in (flash_beat_in),
		.flash_credit  (flash_credit),
		.card_wr       (card_wr),
		.load_result   (load_result),
		.load_busy     (load_busy)
	);

	initial
	begin
		sys_clk = 1'b0;
		forever #2 sys_clk = ~sys_clk;
	end

	//////////////////////////////////////////////////
	// Compare tasks and CRC model
	//////////////////////////////////////////////////

	task automatic check_card_write(input card_wr_t act, input card_wr_t exp);
		checks++;
		if (act !== exp)
		begin
			errors++;
			$display("Fail at %0t: card_wr expected %h got %h", $time, exp, act);
		end
	endtask

	task automatic check_result(input load_status_e act, input load_status_e exp);
		checks++;
		if (act !== exp)
		begin
			errors++;
			$display("Fail at %0t: load_result.status expected %s got %s", $time,
				exp.name(), act.name());
		end
	endtask

	task automatic check_request(input flash_rd_req_t act, input flash_rd_req_t exp);
		checks++;
		if (act !== exp)
		begin
			errors++;
			$display("Fail at %0t: flash_rd_req expected %h got %h", $time, exp, act);
		end
	endtask

	task automatic check_count(input string name, input int exp, input int act);
		checks++;
		if (act != exp)
		begin
			errors++;
			$display("Fail at %0t: %s expected %0d got %0d", $time, name, exp, act);
		end
	endtask

	// Bit serial, LSB first, feedback per bit
	function automatic logic [31:0] crc32_ref(input int n);
		logic [31:0] c;
		logic        fb;
		c = CRC32_INIT;
		for (int i = 0; i < n; i++)
		begin
			for (int b = 0; b < 8; b++)
			begin
				fb = c[0] ^ image[i][b];
				c  = c >> 1;
				if (fb)
					c = c ^ CRC32_POLY;
			end
		end
		return c ^ CRC32_INIT;
	endfunction

	//////////////////////////////////////////////////
	// Flash model with its own credit counter
	//////////////////////////////////////////////////

	always @(negedge sys_clk)
	begin
		flash_beat_in = '0;
		if (!glbl_rst_n)
		begin
			credits = FIFO_DEPTH;
			sending = 1'b0;
			gap_cnt = 0;
		end
		else
		begin
			if (flash_credit)
			begin
				credits++;
				// A credit with no byte of ours left in the FIFO
				if (credits > FIFO_DEPTH)
					extra_credits++;
			end
			if (flash_rd_req.valid)
			begin
				req_count++;
				sending  = 1'b1;
				send_idx = 0;
			end
			if (gap_cnt > 0)
				gap_cnt--;
			else if (sending && credits > 0)
			begin
				flash_beat_in = '{valid: 1'b1, data: image[send_idx],
					last: (send_idx == LOAD_LENGTH - 1)};
				credits--;
				send_idx++;
				if (send_idx == LOAD_LENGTH)
					sending = 1'b0;
				gap_cnt = $unsigned($random(seed)) % (gap_max + 1);
			end
		end
	end

	// Card write and result monitor
	always @(negedge sys_clk)
	begin
		if (glbl_rst_n && card_wr.valid)
		begin
			if (exp_wr.size() == 0)
			begin
				errors++;
				$display("Unexpected card write to address %0d at %0t", card_wr.addr, $time);
			end
			else
				check_card_write(card_wr, exp_wr.pop_front());
		end
		if (glbl_rst_n && load_result.valid)
		begin
			result_count++;
			check_result(load_result.status, exp_status);
		end
	end

	//////////////////////////////////////////////////
	// One complete load
	//////////////////////////////////////////////////

	task automatic run_load(input string name, input int gap, input bit bad_payload,
		input bit bad_crc, input bit extra_start);
		logic [31:0] crc;
		int          err_before;
		int          pos;
		err_before = errors;
		for (int i = 0; i < PAYLOAD_LEN; i++)
			image[i] = 8'($random(seed));
		crc = crc32_ref(PAYLOAD_LEN);
		for (int k = 0; k < 4; k++)
			image[PAYLOAD_LEN + k] = crc[8*k +: 8];
		if (bad_payload)
		begin
			pos = $unsigned($random(seed)) % PAYLOAD_LEN;
			image[pos] = image[pos] ^ 8'h10;
		end
		if (bad_crc)
		begin
			pos = PAYLOAD_LEN + $unsigned($random(seed)) % 4;
			image[pos] = image[pos] ^ 8'h01;
		end
		exp_status = (bad_payload || bad_crc) ? LOAD_CRC_ERROR : LOAD_OK;
		// Writes carry exactly the bytes that go out
		for (int i = 0; i < PAYLOAD_LEN; i++)
			exp_wr.push_back('{valid: 1'b1, addr: CARD_ADDR_W'(i), data: image[i]});
		req_count     = 0;
		result_count  = 0;
		extra_credits = 0;
		gap_max       = gap;
		load_start    = 1'b1;
		@(negedge sys_clk);
		load_start = 1'b0;
		check_request(flash_rd_req, '{valid: 1'b1, addr: BASE_ADDR,
			length: FLASH_LEN_W'(LOAD_LENGTH)});
		if (extra_start)
		begin
			repeat (10) @(negedge sys_clk);
			check_count("load_busy before second start", 1, int'(load_busy));
			load_start = 1'b1;
			@(negedge sys_clk);
			load_start = 1'b0;
		end
		while (result_count == 0)
			@(negedge sys_clk);
		repeat (3) @(negedge sys_clk);
		check_count("load results", 1, result_count);
		check_count("read requests", 1, req_count);
		check_count("missing card writes", 0, exp_wr.size());
		check_count("flash credits after load", FIFO_DEPTH, credits);
		check_count("credits above FIFO depth", 0, extra_credits);
		exp_wr.delete();
		$display("Test %s: %s", name, (errors == err_before) ? "ok" : "errors found");
	endtask

	initial
	begin
		repeat (RESET_CYCLES) @(negedge sys_clk);
		glbl_rst_n = 1'b1;
		@(negedge sys_clk);
		check_count("active outputs after reset", 0, int'({flash_rd_req.valid, flash_credit,
			card_wr.valid, load_result.valid, load_busy}));
		run_load("good image", 2, 1'b0, 1'b0, 1'b0);
		run_load("corrupt payload byte", 3, 1'b1, 1'b0, 1'b0);
		run_load("corrupt stored crc", 1, 1'b0, 1'b1, 1'b0);
		run_load("long gaps", MAX_GAP, 1'b0, 1'b0, 1'b0);
		run_load("back to back", 0, 1'b0, 1'b0, 1'b0);
		run_load("start while busy", 1, 1'b0, 1'b0, 1'b1);
		run_load("series load 1", 0, 1'b0, 1'b0, 1'b0);
		run_load("series load 2", 4, 1'b1, 1'b0, 1'b0);
		run_load("series load 3", 2, 1'b0, 1'b0, 1'b0);
		$display("Tests %0d, checks %0d, errors %0d", NUM_TESTS, checks, errors);
		if (errors == 0)
			$display("Verification passed");
		else
			$display("Verification failed");
		$finish;
	end

	// Watchdog
	initial
	begin
		repeat (RESET_CYCLES + TIMEOUT_CYCLES) @(posedge sys_clk);
		$display("Timeout: the loads did not finish within %0d cycles", TIMEOUT_CYCLES);
		$display("Verification failed");
		$finish;
	end

endmodule
